//--- Bender.yml
package:
  name: simd_div

sources:
  - rtl/vec_pkg.sv
  - rtl/div_pkg.sv
  - rtl/serial_divider.sv
  - rtl/simd_div.sv
  - rtl/simd_div_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/tb_checker.sv
      - bench/tb_simd_div.sv

//--- bench/tb_checker.sv
// Divider lane response checker
module tb_checker (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  vec_pkg::elen_t    a_i,
  input  vec_pkg::elen_t    b_i,
  input  vec_pkg::vdiv_op_e op_i,
  input  vec_pkg::vew_e     vew_i,
  input  vec_pkg::strb_t    be_i,
  input  vec_pkg::strb_t    mask_i,
  input  logic              req_valid_i,
  input  logic              req_ready_i,
  input  vec_pkg::elen_t    res_i,
  input  vec_pkg::strb_t    res_mask_i,
  input  logic              res_valid_i,
  input  logic              res_ready_i,
  input  logic              final_check_i,
  output int                err_cnt_o,
  output int                resp_cnt_o
);

  // Expected responses in request order
  vec_pkg::elen_t exp_res_q[$];
  vec_pkg::strb_t exp_mask_q[$];

  int             err_cnt = 0;
  int             resp_cnt = 0;
  logic           stalled = 1'b0;
  vec_pkg::elen_t held_res;
  vec_pkg::strb_t held_mask;

  assign err_cnt_o  = err_cnt;
  assign resp_cnt_o = resp_cnt;

  // Reference result built element by element with RISC-V division rules
  function automatic vec_pkg::elen_t model_word(vec_pkg::elen_t a, vec_pkg::elen_t b,
                                                vec_pkg::vdiv_op_e op, vec_pkg::vew_e vew,
                                                vec_pkg::strb_t be);
    int unsigned        w;
    int unsigned        n;
    logic               sgn;
    logic               rem;
    vec_pkg::elen_t     wmask, ea, eb, q, r, res;
    logic signed [63:0] sa, sb;
    w     = 8 << int'(vew);
    n     = 8 >> int'(vew);
    sgn   = (op == vec_pkg::VDIV) || (op == vec_pkg::VREM);
    rem   = (op == vec_pkg::VREMU) || (op == vec_pkg::VREM);
    wmask = {vec_pkg::ELEN{1'b1}} >> (vec_pkg::ELEN - w);
    res   = '0;
    for (int i = 0; i < n; i++) begin
      // Elements with a low enable on their first byte stay zero
      if (be[i * (w / 8)]) begin
        ea = (a >> (i * w)) & wmask;
        eb = (b >> (i * w)) & wmask;
        if (sgn && ea[w-1]) ea = ea | ~wmask;
        if (sgn && eb[w-1]) eb = eb | ~wmask;
        sa = ea;
        sb = eb;
        if (eb == '0) begin
          q = '1;
          r = ea;
        end else if (sgn && ea == 64'h8000_0000_0000_0000 && eb == '1) begin
          q = ea;
          r = '0;
        end else if (sgn) begin
          q = sa / sb;
          r = sa % sb;
        end else begin
          q = ea / eb;
          r = ea % eb;
        end
        res = res | (((rem ? r : q) & wmask) << (i * w));
      end
    end
    return res;
  endfunction

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // A stalled response must stay presented and unchanged
      if (stalled && !res_valid_i) begin
        $display("Response valid dropped at time %0t before it was accepted", $time);
        err_cnt++;
      end else if (stalled && (res_i !== held_res || res_mask_i !== held_mask)) begin
        $display("ERR %0t: stalled response changed from %h/%h to %h/%h", $time,
                 held_res, held_mask, res_i, res_mask_i);
        err_cnt++;
      end
      if (res_valid_i && res_ready_i) begin
        resp_cnt++;
        if (exp_res_q.size() == 0) begin
          $display("Extra response at time %0t with no request outstanding", $time);
          err_cnt++;
        end else begin
          if (res_i !== exp_res_q[0] || res_mask_i !== exp_mask_q[0]) begin
            $display("ERR %0t: result %h mask %h, expected result %h mask %h", $time,
                     res_i, res_mask_i, exp_res_q[0], exp_mask_q[0]);
            err_cnt++;
          end
          void'(exp_res_q.pop_front());
          void'(exp_mask_q.pop_front());
        end
      end
      if (req_valid_i && req_ready_i) begin
        exp_res_q.push_back(model_word(a_i, b_i, op_i, vew_i, be_i));
        exp_mask_q.push_back(mask_i);
      end
      stalled   = res_valid_i && !res_ready_i;
      held_res  = res_i;
      held_mask = res_mask_i;
    end
  end

  // Requests still waiting at the end never got their result
  always @(posedge final_check_i) begin
    if (exp_res_q.size() != 0) begin
      $display("Missing responses: %0d accepted requests never returned a result",
               exp_res_q.size());
      err_cnt++;
    end
  end

endmodule

//--- bench/tb_clock.sv
// Bench clock and reset
module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // Period of four time units
  initial clk_o = 1'b0;
  always #2 clk_o = ~clk_o;

  // Reset is held low for four cycles and released away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- bench/tb_simd_div.sv
// Vector divider lane testbench
module tb_simd_div;

  localparam logic [31:0] LFSR_SEED = 32'hbaeae828;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;
  localparam int          REQS_PER_TEST = 24;
  localparam int          REQS_STALL = 32;
  localparam int          NUM_REQS = 4 * REQS_PER_TEST + REQS_STALL;
  // Worst case per request is eight elements through the divider plus some slack
  localparam int          TIMEOUT_CYCLES = NUM_REQS * (8 * (div_pkg::DIV_STEPS + 4) + 20);

  logic              clk, rst_n;
  vec_pkg::elen_t    operand_a, operand_b, result;
  vec_pkg::vdiv_op_e op;
  vec_pkg::vew_e     vew;
  vec_pkg::strb_t    be, mask, res_mask;
  logic              valid_in, ready_out, valid_out, ready_in;
  logic              final_check;
  int                chk_errs, resp_cnt;
  int                bench_errs = 0;
  int                sent = 0;
  int                cycles = 0;
  logic              stall_en = 1'b0;
  logic [31:0]       lfsr_q = LFSR_SEED;

  tb_clock i_clock (.clk_o(clk), .rst_no(rst_n));

  simd_div_top DUT (
    .clk_i(clk), .rst_ni(rst_n), .operand_a_i(operand_a), .operand_b_i(operand_b),
    .op_i(op), .vew_i(vew), .be_i(be), .mask_i(mask), .valid_i(valid_in),
    .ready_o(ready_out), .result_o(result), .mask_o(res_mask), .valid_o(valid_out),
    .ready_i(ready_in)
  );

  tb_checker i_checker (
    .clk_i(clk), .rst_ni(rst_n), .a_i(operand_a), .b_i(operand_b), .op_i(op), .vew_i(vew),
    .be_i(be), .mask_i(mask), .req_valid_i(valid_in), .req_ready_i(ready_out),
    .res_i(result), .res_mask_i(res_mask), .res_valid_i(valid_out), .res_ready_i(ready_in),
    .final_check_i(final_check), .err_cnt_o(chk_errs), .resp_cnt_o(resp_cnt)
  );

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit that is taken
  function automatic logic [63:0] rand_bits(int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // Overwrite element idx of a word
  function automatic vec_pkg::elen_t put_elem(vec_pkg::elen_t word, int unsigned w,
                                              int unsigned idx, vec_pkg::elen_t val);
    vec_pkg::elen_t wmask;
    wmask = {vec_pkg::ELEN{1'b1}} >> (vec_pkg::ELEN - w);
    return (word & ~(wmask << (idx * w))) | ((val & wmask) << (idx * w));
  endfunction

  // Every wait goes through one falling edge, where ready_i is also redrawn
  task automatic tick();
    @(negedge clk);
    ready_in = stall_en ? 1'(rand_bits(1)) : 1'b1;
  endtask

  // Hold the request until ready_o is seen at a falling edge, then pass the rising edge
  task automatic send_req();
    valid_in = 1'b1;
    while (!ready_out) tick();
    tick();
    sent++;
  endtask

  // Kind 1 unsigned, 2 signed, 3 corner lanes, 4 random enables, 5 back-pressure
  task automatic make_req(input int kind);
    int unsigned w;
    logic [1:0]  sel;
    op        = vec_pkg::vdiv_op_e'(rand_bits(2));
    vew       = vec_pkg::vew_e'(rand_bits(2));
    operand_a = rand_bits(64);
    // Sparse divisors give quotients of many sizes
    operand_b = rand_bits(64) & rand_bits(64) & rand_bits(64);
    mask      = 8'(rand_bits(8));
    be        = 8'hff;
    w         = 8 << int'(vew);
    if (kind == 1) op = rand_bits(1) ? vec_pkg::VREMU : vec_pkg::VDIVU;
    if (kind == 2) op = rand_bits(1) ? vec_pkg::VREM : vec_pkg::VDIV;
    if (kind == 2) operand_b = rand_bits(64);
    if (kind == 3) begin
      for (int i = 0; i < 64 / w; i++) begin
        sel = 2'(rand_bits(2));
        if (sel == 2'd1) operand_b = put_elem(operand_b, w, i, '0);
        if (sel == 2'd2) operand_a = put_elem(operand_a, w, i, 64'd1 << (w - 1));
        if (sel == 2'd2) operand_b = put_elem(operand_b, w, i, '1);
        if (sel == 2'd3) operand_a = put_elem(operand_a, w, i, '0);
      end
    end
    if (kind >= 4) be = (rand_bits(2) == 2'd0) ? 8'h00 : 8'(rand_bits(8));
  endtask

  task automatic run_test(input string name, input int kind, input int count);
    int errs_before;
    errs_before = chk_errs;
    stall_en    = (kind == 5);
    for (int i = 0; i < count; i++) begin
      make_req(kind);
      send_req();
    end
    valid_in = 1'b0;
    while (resp_cnt != sent) tick();
    stall_en = 1'b0;
    tick();
    $display("Test %0d %s: %0d requests, %0d errors", kind, name, count,
             chk_errs - errs_before);
  endtask

  // Cycle limit so that a stuck handshake cannot hang the run
  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d responses received",
               cycles, resp_cnt, sent);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    operand_a   = '0;
    operand_b   = '0;
    op          = vec_pkg::VDIVU;
    vew         = vec_pkg::EW8;
    be          = '0;
    mask        = '0;
    valid_in    = 1'b0;
    ready_in    = 1'b1;
    final_check = 1'b0;
    @(posedge rst_n);
    tick();
    if (!ready_out || valid_out) begin
      $display("Idle state wrong after reset: ready_o is %b and valid_o is %b",
               ready_out, valid_out);
      bench_errs++;
    end
    run_test("unsigned divide and remainder", 1, REQS_PER_TEST);
    run_test("signed divide and remainder", 2, REQS_PER_TEST);
    run_test("zero divisor, overflow and zero dividend", 3, REQS_PER_TEST);
    run_test("random byte enables", 4, REQS_PER_TEST);
    run_test("back-pressure with back-to-back requests", 5, REQS_STALL);
    final_check = 1'b1;
    tick();
    tick();
    $display("Totals: %0d requests, %0d responses, %0d errors", sent, resp_cnt,
             chk_errs + bench_errs);
    if (chk_errs + bench_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- rtl/div_pkg.sv
// Serial divider definitions
package div_pkg;

  // Bit 0 selects signed division and bit 1 selects the remainder
  typedef enum logic [1:0] {
    DIV_UDIV = 2'b00,
    DIV_SDIV = 2'b01,
    DIV_UREM = 2'b10,
    DIV_SREM = 2'b11
  } div_opcode_e;

  // Element counter width that covers eight byte elements
  localparam int unsigned CNT_W = 3;

  // Shift-subtract iterations for one element
  localparam int unsigned DIV_STEPS = 64;

endpackage

//--- rtl/serial_divider.sv
// Radix-2 serial integer divider
module serial_divider (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vec_pkg::elen_t        op_a_i,
  input  vec_pkg::elen_t        op_b_i,
  input  div_pkg::div_opcode_e  opcode_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output vec_pkg::elen_t        res_o
);

  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_FINISH, DIV_DONE} div_state_e;

  div_state_e state_d, state_q;
  logic [$clog2(div_pkg::DIV_STEPS)-1:0] step_d, step_q;

  // Operand preparation at acceptance
  logic           in_hs;
  logic           a_neg_in, b_neg_in;
  vec_pkg::elen_t abs_a, abs_b;

  // Per element flags and working registers
  logic           rem_sel_q, a_neg_q, b_neg_q, zero_q, ovf_q;
  vec_pkg::elen_t dividend_q, divisor_q, quo_q, rem_q, res_q;

  // One restoring step and the final correction
  logic [vec_pkg::ELEN:0]   partial;
  logic [vec_pkg::ELEN+1:0] diff;
  vec_pkg::elen_t           quo_step, rem_step;
  vec_pkg::elen_t           quo_fix, rem_fix;

  assign in_ready_o  = (state_q == DIV_IDLE);
  assign out_valid_o = (state_q == DIV_DONE);
  assign res_o       = res_q;
  assign in_hs       = in_valid_i && in_ready_o;

  // Signs only matter for the signed opcodes
  assign a_neg_in = opcode_i[0] & op_a_i[vec_pkg::ELEN-1];
  assign b_neg_in = opcode_i[0] & op_b_i[vec_pkg::ELEN-1];
  // The most negative value maps onto itself, which is its correct unsigned magnitude
  assign abs_a    = a_neg_in ? -op_a_i : op_a_i;
  assign abs_b    = b_neg_in ? -op_b_i : op_b_i;

  // Shift the next dividend bit into the partial remainder and try to subtract
  assign partial  = {rem_q, quo_q[vec_pkg::ELEN-1]};
  assign diff     = {1'b0, partial} - {2'b00, divisor_q};
  // A borrow restores the shifted value, otherwise the difference is kept
  assign rem_step = diff[vec_pkg::ELEN+1] ? partial[vec_pkg::ELEN-1:0]
                                          : diff[vec_pkg::ELEN-1:0];
  assign quo_step = {quo_q[vec_pkg::ELEN-2:0], ~diff[vec_pkg::ELEN+1]};

  // Sign correction and the RISC-V special cases
  always_comb begin
    quo_fix = (a_neg_q ^ b_neg_q) ? -quo_q : quo_q;
    rem_fix = a_neg_q ? -rem_q : rem_q;
    if (zero_q) begin
      // Division by zero returns all ones and leaves the dividend as remainder
      quo_fix = '1;
      rem_fix = dividend_q;
    end else if (ovf_q) begin
      // Most negative value over minus one returns the dividend with no remainder
      quo_fix = dividend_q;
      rem_fix = '0;
    end
  end

  // Control FSM
  always_comb begin
    state_d = state_q;
    step_d  = step_q;
    case (state_q)
      DIV_IDLE: begin
        if (in_valid_i) begin
          state_d = DIV_RUN;
          step_d  = '0;
        end
      end
      DIV_RUN: begin
        // One quotient bit per cycle until the last step
        if (int'(step_q) == div_pkg::DIV_STEPS - 1) begin
          state_d = DIV_FINISH;
        end else begin
          step_d = step_q + 1'b1;
        end
      end
      DIV_FINISH: begin
        state_d = DIV_DONE;
      end
      DIV_DONE: begin
        // Hold the result and block new operands until it is taken
        if (out_ready_i) begin
          state_d = DIV_IDLE;
        end
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      step_q  <= step_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_hs) begin
      rem_sel_q  <= opcode_i[1];
      a_neg_q    <= a_neg_in;
      b_neg_q    <= b_neg_in;
      zero_q     <= (op_b_i == '0);
      ovf_q      <= opcode_i[0] && (op_a_i == {1'b1, {(vec_pkg::ELEN-1){1'b0}}})
                    && (op_b_i == '1);
      dividend_q <= op_a_i;
      divisor_q  <= abs_b;
      quo_q      <= abs_a;
      rem_q      <= '0;
    end else if (state_q == DIV_RUN) begin
      quo_q <= quo_step;
      rem_q <= rem_step;
    end
    if (state_q == DIV_FINISH) begin
      res_q <= rem_sel_q ? rem_fix : quo_fix;
    end
  end

endmodule

//--- rtl/simd_div.sv
// Vector divider request sequencer
module simd_div (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vec_pkg::elen_t        operand_a_i,
  input  vec_pkg::elen_t        operand_b_i,
  input  vec_pkg::vdiv_op_e     op_i,
  input  vec_pkg::vew_e         vew_i,
  input  vec_pkg::strb_t        be_i,
  input  vec_pkg::strb_t        mask_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output vec_pkg::elen_t        result_o,
  output vec_pkg::strb_t        mask_o,
  output logic                  valid_o,
  input  logic                  ready_i,
  output vec_pkg::elen_t        div_op_a_o,
  output vec_pkg::elen_t        div_op_b_o,
  output div_pkg::div_opcode_e  div_opcode_o,
  output logic                  div_in_valid_o,
  input  logic                  div_in_ready_i,
  input  logic                  div_out_valid_i,
  output logic                  div_out_ready_o,
  input  vec_pkg::elen_t        div_result_i
);

  typedef enum logic [1:0] {ISSUE_IDLE, ISSUE_RUN, ISSUE_WAIT} issue_state_e;
  typedef enum logic [1:0] {COMMIT_IDLE, COMMIT_RUN, COMMIT_DONE} commit_state_e;

  issue_state_e  issue_state_d, issue_state_q;
  commit_state_e commit_state_d, commit_state_q;

  // The latched request stays stable until the response is taken
  vec_pkg::elen_t    opa_q, opb_q;
  vec_pkg::vdiv_op_e op_q;
  vec_pkg::vew_e     vew_q;
  vec_pkg::strb_t    be_q, mask_q;

  // Packed result under construction
  vec_pkg::elen_t result_d, result_q;
  vec_pkg::elen_t shifted_result, inserted_elem;

  // Element counters start at the highest index
  logic [div_pkg::CNT_W-1:0] issue_cnt_d, issue_cnt_q;
  logic [div_pkg::CNT_W-1:0] commit_cnt_d, commit_cnt_q;
  logic [div_pkg::CNT_W-1:0] cnt_init;

  logic req_hs;
  logic signed_op;
  logic issue_en, commit_en;
  logic commit_step;

  // Byte index of the lowest byte of element cnt
  function automatic logic [div_pkg::CNT_W-1:0] first_byte(logic [div_pkg::CNT_W-1:0] cnt,
                                                           vec_pkg::vew_e vew);
    case (vew)
      vec_pkg::EW8:  return cnt;
      vec_pkg::EW16: return {cnt[1:0], 1'b0};
      vec_pkg::EW32: return {cnt[0], 2'b00};
      default:       return '0;
    endcase
  endfunction

  // Pick element cnt out of a word and widen it to the full lane
  function automatic vec_pkg::elen_t extend_elem(vec_pkg::elen_t word, vec_pkg::vew_e vew,
                                                 logic [div_pkg::CNT_W-1:0] cnt, logic sgn);
    logic [7:0]  e8;
    logic [15:0] e16;
    logic [31:0] e32;
    e8  = word[8*cnt +: 8];
    e16 = word[16*cnt[1:0] +: 16];
    e32 = word[32*cnt[0] +: 32];
    case (vew)
      vec_pkg::EW8:  return {{56{sgn & e8[7]}}, e8};
      vec_pkg::EW16: return {{48{sgn & e16[15]}}, e16};
      vec_pkg::EW32: return {{32{sgn & e32[31]}}, e32};
      default:       return word;
    endcase
  endfunction

  assign ready_o  = (issue_state_q == ISSUE_IDLE);
  assign valid_o  = (commit_state_q == COMMIT_DONE);
  assign req_hs   = valid_i && ready_o;
  assign result_o = result_q;
  assign mask_o   = mask_q;

  // Highest element index for the requested width
  always_comb begin
    case (vew_i)
      vec_pkg::EW8:  cnt_init = 3'd7;
      vec_pkg::EW16: cnt_init = 3'd3;
      vec_pkg::EW32: cnt_init = 3'd1;
      default:       cnt_init = 3'd0;
    endcase
  end

  // An element counts as enabled when the enable of its first byte is set
  assign issue_en  = be_q[first_byte(issue_cnt_q, vew_q)];
  assign commit_en = be_q[first_byte(commit_cnt_q, vew_q)];

  // Signed operations sign-extend and the others zero-extend
  assign signed_op  = (op_q == vec_pkg::VDIV) || (op_q == vec_pkg::VREM);
  assign div_op_a_o = extend_elem(opa_q, vew_q, issue_cnt_q, signed_op);
  assign div_op_b_o = extend_elem(opb_q, vew_q, issue_cnt_q, signed_op);

  always_comb begin
    case (op_q)
      vec_pkg::VDIV:  div_opcode_o = div_pkg::DIV_SDIV;
      vec_pkg::VREMU: div_opcode_o = div_pkg::DIV_UREM;
      vec_pkg::VREM:  div_opcode_o = div_pkg::DIV_SREM;
      default:        div_opcode_o = div_pkg::DIV_UDIV;
    endcase
  end

  // The issue FSM spends one divider handshake per element or one cycle per skipped element
  always_comb begin
    issue_state_d  = issue_state_q;
    issue_cnt_d    = issue_cnt_q;
    div_in_valid_o = 1'b0;
    case (issue_state_q)
      ISSUE_IDLE: begin
        if (req_hs) begin
          issue_cnt_d   = cnt_init;
          issue_state_d = ISSUE_RUN;
        end
      end
      ISSUE_RUN: begin
        div_in_valid_o = issue_en;
        if (!issue_en || div_in_ready_i) begin
          if (issue_cnt_q == '0) begin
            issue_state_d = ISSUE_WAIT;
          end else begin
            issue_cnt_d = issue_cnt_q - 1'b1;
          end
        end
      end
      ISSUE_WAIT: begin
        // The latched request feeds the commit path until the response leaves
        if (valid_o && ready_i) begin
          issue_state_d = ISSUE_IDLE;
        end
      end
      default: begin
        issue_state_d = ISSUE_IDLE;
      end
    endcase
  end

  // Commit FSM walks the same elements in the same order
  assign commit_step     = (commit_state_q == COMMIT_RUN) && (!commit_en || div_out_valid_i);
  assign div_out_ready_o = (commit_state_q == COMMIT_RUN) && commit_en;

  always_comb begin
    commit_state_d = commit_state_q;
    commit_cnt_d   = commit_cnt_q;
    case (commit_state_q)
      COMMIT_IDLE: begin
        if (req_hs) begin
          commit_cnt_d   = cnt_init;
          commit_state_d = COMMIT_RUN;
        end
      end
      COMMIT_RUN: begin
        if (commit_step) begin
          if (commit_cnt_q == '0) begin
            commit_state_d = COMMIT_DONE;
          end else begin
            commit_cnt_d = commit_cnt_q - 1'b1;
          end
        end
      end
      COMMIT_DONE: begin
        if (ready_i) begin
          commit_state_d = COMMIT_IDLE;
        end
      end
      default: begin
        commit_state_d = COMMIT_IDLE;
      end
    endcase
  end

  // Elements arrive highest first, so each one pushes the earlier ones up
  always_comb begin
    case (vew_q)
      vec_pkg::EW8: begin
        shifted_result = result_q << 8;
        inserted_elem  = {56'b0, div_result_i[7:0]};
      end
      vec_pkg::EW16: begin
        shifted_result = result_q << 16;
        inserted_elem  = {48'b0, div_result_i[15:0]};
      end
      vec_pkg::EW32: begin
        shifted_result = result_q << 32;
        inserted_elem  = {32'b0, div_result_i[31:0]};
      end
      default: begin
        shifted_result = '0;
        inserted_elem  = div_result_i;
      end
    endcase
    // Skipped elements read as zero
    if (!commit_en) begin
      inserted_elem = '0;
    end
    result_d = commit_step ? (shifted_result | inserted_elem) : result_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_state_q  <= ISSUE_IDLE;
      commit_state_q <= COMMIT_IDLE;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
    end else begin
      issue_state_q  <= issue_state_d;
      commit_state_q <= commit_state_d;
      issue_cnt_q    <= issue_cnt_d;
      commit_cnt_q   <= commit_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      opa_q  <= operand_a_i;
      opb_q  <= operand_b_i;
      op_q   <= op_i;
      vew_q  <= vew_i;
      be_q   <= be_i;
      mask_q <= mask_i;
    end
    result_q <= result_d;
  end

endmodule

//--- rtl/simd_div_top.sv
// Vector divider lane top level
module simd_div_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vec_pkg::elen_t     operand_a_i,
  input  vec_pkg::elen_t     operand_b_i,
  input  vec_pkg::vdiv_op_e  op_i,
  input  vec_pkg::vew_e      vew_i,
  input  vec_pkg::strb_t     be_i,
  input  vec_pkg::strb_t     mask_i,
  input  logic               valid_i,
  output logic               ready_o,
  output vec_pkg::elen_t     result_o,
  output vec_pkg::strb_t     mask_o,
  output logic               valid_o,
  input  logic               ready_i
);

  // Element port from the sequencer to the divider
  vec_pkg::elen_t       div_op_a, div_op_b;
  div_pkg::div_opcode_e div_opcode;
  logic                 div_in_valid, div_in_ready;

  // Result port from the divider back to the sequencer
  vec_pkg::elen_t div_result;
  logic           div_out_valid, div_out_ready;

  simd_div i_simd_div (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .op_i            (op_i),
    .vew_i           (vew_i),
    .be_i            (be_i),
    .mask_i          (mask_i),
    .valid_i         (valid_i),
    .ready_o         (ready_o),
    .result_o        (result_o),
    .mask_o          (mask_o),
    .valid_o         (valid_o),
    .ready_i         (ready_i),
    .div_op_a_o      (div_op_a),
    .div_op_b_o      (div_op_b),
    .div_opcode_o    (div_opcode),
    .div_in_valid_o  (div_in_valid),
    .div_in_ready_i  (div_in_ready),
    .div_out_valid_i (div_out_valid),
    .div_out_ready_o (div_out_ready),
    .div_result_i    (div_result)
  );

  serial_divider i_serial_divider (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_a_i      (div_op_a),
    .op_b_i      (div_op_b),
    .opcode_i    (div_opcode),
    .in_valid_i  (div_in_valid),
    .in_ready_o  (div_in_ready),
    .out_valid_o (div_out_valid),
    .out_ready_i (div_out_ready),
    .res_o       (div_result)
  );

endmodule

//--- rtl/vec_pkg.sv
// Vector lane definitions
package vec_pkg;

  // Width of one vector lane in bits
  localparam int unsigned ELEN = 64;

  // Number of bytes in one lane word
  localparam int unsigned ELENB = ELEN / 8;

  // One lane word carrying packed elements
  typedef logic [ELEN-1:0] elen_t;

  // One bit per byte for the byte enables and for the mask
  typedef logic [ELENB-1:0] strb_t;

  // Element width of a request
  typedef enum logic [1:0] {
    EW8  = 2'b00,
    EW16 = 2'b01,
    EW32 = 2'b10,
    EW64 = 2'b11
  } vew_e;

  // Integer divide operations of the vector unit
  typedef enum logic [1:0] {
    VDIVU = 2'b00,
    VDIV  = 2'b01,
    VREMU = 2'b10,
    VREM  = 2'b11
  } vdiv_op_e;

endpackage

//--- simd_div_top.f
rtl/vec_pkg.sv
rtl/div_pkg.sv
rtl/serial_divider.sv
rtl/simd_div.sv
rtl/simd_div_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_simd_div.sv
